// File: led_matrix.f
verilog/led_matrix_pkg.sv
verilog/scan_ctrl_if.sv
verilog/scan_fsm.sv
verilog/scan_counters.sv
verilog/dac_spi_writer.sv
verilog/frame_buffer.sv
verilog/led_matrix_top.sv
tests/led_matrix_properties.sv
tests/tb_led_matrix.sv

// File: run_sim.sh
#!/bin/sh
# Builds the LED matrix testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_led_matrix -f led_matrix.f -o sim_led_matrix

./obj_dir/sim_led_matrix | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "result: PASS"
  exit 0
else
  echo "result: FAIL"
  exit 1
fi

// File: tests/led_matrix_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line and DAC protocol properties, bound to the
// scanner top level by the testbench.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module led_matrix_properties (
  input logic                            clk_i,
  input logic                            rst_i,
  input logic [led_matrix_pkg::ROWS-1:0] row_o,
  input logic [led_matrix_pkg::COLS-1:0] col_o,
  input logic                            busy_o,
  input logic                            dac_cs_o
);

  // at most one line of each kind is driven.
  row_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(row_o))
    else $error("more than one row line driven");
  col_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(col_o))
    else $error("more than one column line driven");

  // a column only lights inside an active row.
  col_needs_row: assert property (@(posedge clk_i) disable iff (rst_i)
    (col_o != '0) |-> (row_o != '0))
    else $error("column line driven with no row line");

  // the DAC is never selected while the scanner idles.
  cs_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
    !busy_o |-> dac_cs_o)
    else $error("DAC chip select low while idle");

endmodule

// File: tests/led_matrix_vectors.txt
blank          0000 000 0 0
full           ffff fff 0 0
diagonal       8421 5a5 0 0
anti_diagonal  1248 a5a 0 0
checker        a5a5 123 0 0
corners        9009 800 0 0
first_pixel    0001 001 0 0
last_pixel     8000 7fe 0 0
restart_dac    3c3c 456 1 5
restart_scan   0ff0 9ab 1 60
restart_late   f00f 6c3 1 120
reset_in_dac   ffff 321 2 20
reset_in_scan  5555 abc 2 80

// File: tests/tb_led_matrix.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the LED matrix scanner. Each vector line
// gives name, frame, level, mode (0 plain, 1 second start,
// 2 reset) and the scan cycle from which the mode acts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_led_matrix;

  logic                               clk_i;
  logic                               rst_i;
  logic                               start_i;
  logic [led_matrix_pkg::LEVEL_W-1:0] level_i;
  logic                               wr_en_i;
  logic [led_matrix_pkg::PIXELS-1:0]  wr_frame_i;
  logic [led_matrix_pkg::ROWS-1:0]    row_o;
  logic [led_matrix_pkg::COLS-1:0]    col_o;
  logic                               busy_o;
  logic                               done_o;
  logic                               dac_sclk_o;
  logic                               dac_din_o;
  logic                               dac_cs_o;

  string       names[$];
  logic [15:0] frames[$];
  logic [11:0] levels[$];
  int          modes[$];
  int          ats[$];
  logic [15:0] model_frame = '0;
  int          limit_cycles = 0;

  led_matrix_top led_matrix_top_inst (.*);

  bind led_matrix_top led_matrix_properties led_matrix_properties_inst (
    .clk_i(clk_i), .rst_i(rst_i), .row_o(row_o), .col_o(col_o),
    .busy_o(busy_o), .dac_cs_o(dac_cs_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input string what,
                             input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED test=%s %s expected=%0h actual=%0h",
               name, what, expected, actual);
      $display("sim failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one scan, sampled on the falling edge
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_scan(input string name, input logic [15:0] frame,
                          input logic [11:0] level, input int mode, input int at,
                          input bit do_write);
    int          cycle;
    int          stretches;
    int          run_len;
    int          edges;
    int          exp_row;
    int          exp_col;
    bit          finished;
    bit          sclk_prev;
    bit          reset_due;
    logic [15:0] dac_word;
    cycle = 0;
    stretches = 0;
    run_len = 0;
    edges = 0;
    finished = 1'b0;
    sclk_prev = 1'b0;
    reset_due = 1'b0;
    dac_word = '0;
    @(posedge clk_i);
    if (do_write) begin
      wr_en_i <= 1'b1;
      wr_frame_i <= frame;
      model_frame = frame;
      @(posedge clk_i);
      wr_en_i <= 1'b0;
    end
    start_i <= 1'b1;
    level_i <= level;
    while (!finished) begin
      @(posedge clk_i);
      start_i <= (mode == 1) && (cycle == at);
      if (reset_due) begin
        rst_i <= 1'b1;
      end
      @(negedge clk_i);
      if (reset_due) begin
        check_value(name, "row after reset", 0, int'(row_o));
        check_value(name, "column after reset", 0, int'(col_o));
        check_value(name, "busy after reset", 0, int'(busy_o));
        check_value(name, "done after reset", 1, int'(done_o));
        check_value(name, "chip select after reset", 1, int'(dac_cs_o));
        // the frame store is cleared by reset too.
        model_frame = '0;
        @(posedge clk_i);
        rst_i <= 1'b0;
        finished = 1'b1;
      end else begin
        // DAC bits are taken on each rising serial clock.
        if (dac_sclk_o && !sclk_prev && !dac_cs_o) begin
          dac_word = {dac_word[14:0], dac_din_o};
          edges++;
        end
        sclk_prev = dac_sclk_o;
        if (row_o != '0) begin
          exp_row = 1 << (stretches / led_matrix_pkg::COLS);
          exp_col = model_frame[stretches[3:0]] ?
                    (1 << (stretches % led_matrix_pkg::COLS)) : 0;
          check_value(name, "row lines", exp_row, int'(row_o));
          check_value(name, "column lines", exp_col, int'(col_o));
          run_len++;
        end else if (run_len != 0) begin
          check_value(name, "dwell length", led_matrix_pkg::DWELL_CYCLES, run_len);
          stretches++;
          run_len = 0;
        end
        // reset goes in while the DAC or a lit column has a cycle left.
        reset_due = (mode == 2) && (cycle >= at) &&
                    ((!dac_cs_o && edges < led_matrix_pkg::DAC_WORD_W) ||
                     (col_o != '0 && run_len == 1));
        if (done_o) begin
          finished = 1'b1;
          check_value(name, "pixel count", led_matrix_pkg::PIXELS, stretches);
          check_value(name, "sclk edges", led_matrix_pkg::DAC_WORD_W, edges);
          check_value(name, "dac word", int'({led_matrix_pkg::DAC_CMD, level}),
                      int'(dac_word));
          check_value(name, "busy at end", 0, int'(busy_o));
        end else begin
          check_value(name, "busy in scan", 1, int'(busy_o));
        end
      end
      cycle++;
    end
  endtask

  initial begin
    int          fd;
    string       name;
    logic [15:0] frame;
    logic [11:0] level;
    int          mode;
    int          at;
    rst_i = 1'b1;
    start_i = 1'b0;
    level_i = '0;
    wr_en_i = 1'b0;
    wr_frame_i = '0;
    fd = $fopen("tests/led_matrix_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tests/led_matrix_vectors.txt");
      $display("sim failed");
      $fatal(1, "no vector file");
    end
    while ($fscanf(fd, "%s %h %h %d %d\n", name, frame, level, mode, at) == 5) begin
      names.push_back(name);
      frames.push_back(frame);
      levels.push_back(level);
      modes.push_back(mode);
      ats.push_back(at);
    end
    $fclose(fd);
    limit_cycles = names.size() * 200 + 500;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("power_on", "done", 1, int'(done_o));
    check_value("power_on", "chip select", 1, int'(dac_cs_o));
    check_value("power_on", "test count", 1, int'(names.size() > 0));
    foreach (names[i]) begin
      run_scan(names[i], frames[i], levels[i], modes[i], ats[i], 1'b1);
      if (modes[i] == 2) begin
        run_scan(names[i], 16'h0000, levels[i], 0, 0, 1'b0);
      end
    end
    $display("sim passed");
    $finish;
  end

  // watchdog sized from the number of tests.
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("timeout: scans did not finish within %0d cycles", limit_cycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verilog/dac_spi_writer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial writer for the brightness DAC. A start
// pulse sends command and level MSB first, then
// done pulses once.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dac_spi_writer (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               start_i,
  input  logic [led_matrix_pkg::LEVEL_W-1:0] level_i,
  output logic                               done_o,
  output logic                               sclk_o,
  output logic                               din_o,
  output logic                               cs_o
);

  logic [led_matrix_pkg::DAC_WORD_W-1:0] shift_q;
  logic [led_matrix_pkg::DAC_CNT_W-1:0]  bit_cnt_q;
  logic                                  last_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cs_o      <= 1'b1;
      sclk_o    <= 1'b0;
      shift_q   <= '0;
      bit_cnt_q <= '0;
      last_q    <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      last_q <= 1'b0;
      done_o <= last_q;
      if (cs_o) begin
        if (start_i) begin
          cs_o      <= 1'b0;
          sclk_o    <= 1'b0;
          shift_q   <= {led_matrix_pkg::DAC_CMD, level_i};
          bit_cnt_q <= '0;
        end
      end else begin
        sclk_o    <= ~sclk_o;
        bit_cnt_q <= bit_cnt_q + 1'b1;
        // next bit goes out on the falling edge.
        if (sclk_o) begin
          shift_q <= shift_q << 1;
        end
        if (bit_cnt_q ==
            led_matrix_pkg::DAC_CNT_W'(led_matrix_pkg::DAC_SPI_CYCLES - 1)) begin
          cs_o   <= 1'b1;
          sclk_o <= 1'b0;
          last_q <= 1'b1;
        end
      end
    end
  end

  // shift register is empty once all bits have gone out.
  assign din_o = shift_q[led_matrix_pkg::DAC_WORD_W-1];

endmodule

// File: verilog/frame_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-bit-per-pixel frame store. The host writes a
// whole frame; the scanner reads one pixel at a time.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frame_buffer (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              wr_en_i,
  input  logic [led_matrix_pkg::PIXELS-1:0] wr_data_i,
  input  logic [led_matrix_pkg::ROW_W-1:0]  row_i,
  input  logic [led_matrix_pkg::COL_W-1:0]  col_i,
  output logic                              pixel_o
);

  logic [led_matrix_pkg::PIXELS-1:0]    frame_q;
  logic [led_matrix_pkg::PIX_IDX_W-1:0] pix_idx;

  // writes land at any time, even mid-scan.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      frame_q <= '0;
    end else if (wr_en_i) begin
      frame_q <= wr_data_i;
    end
  end

  // raster index, bit 0 is row 0 column 0.
  always_comb begin
    pix_idx = led_matrix_pkg::PIX_IDX_W'(row_i) *
              led_matrix_pkg::PIX_IDX_W'(led_matrix_pkg::COLS) +
              led_matrix_pkg::PIX_IDX_W'(col_i);
  end

  assign pixel_o = frame_q[pix_idx];

endmodule

// File: verilog/led_matrix_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants and types for the LED matrix
// scanner. Every block refers to these by scoped name.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package led_matrix_pkg;

  // matrix geometry.
  localparam int ROWS      = 4;
  localparam int COLS      = 4;
  localparam int ROW_W     = 2;
  localparam int COL_W     = 2;
  localparam int PIXELS    = ROWS * COLS;
  localparam int PIX_IDX_W = ROW_W + COL_W;

  // time each pixel is shown, and the timer that measures it.
  localparam int DWELL_CYCLES = 4;
  localparam int DWELL_W      = 2;

  // serial DAC word is the command nibble above the level.
  localparam int             LEVEL_W        = 12;
  localparam logic [3:0]     DAC_CMD        = 4'h3;
  localparam int             DAC_WORD_W     = 16;
  localparam int             DAC_SPI_CYCLES = 2 * DAC_WORD_W;
  localparam int             DAC_CNT_W      = 5;

  typedef enum logic [1:0] {
    OP_CLEAR = 2'b00,
    OP_HOLD  = 2'b01,
    OP_INC   = 2'b10
  } cnt_op_t;

  typedef enum logic [2:0] {
    S_IDLE, S_DAC_START, S_DAC_WAIT, S_DWELL,
    S_COL_STEP, S_COL_TEST, S_ROW_STEP, S_ROW_TEST
  } scan_state_t;

endpackage

// File: verilog/led_matrix_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED matrix scanner top level. Write a frame, then
// pulse start with a brightness level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module led_matrix_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               start_i,
  input  logic [led_matrix_pkg::LEVEL_W-1:0] level_i,
  input  logic                               wr_en_i,
  input  logic [led_matrix_pkg::PIXELS-1:0]  wr_frame_i,
  output logic [led_matrix_pkg::ROWS-1:0]    row_o,
  output logic [led_matrix_pkg::COLS-1:0]    col_o,
  output logic                               busy_o,
  output logic                               done_o,
  output logic                               dac_sclk_o,
  output logic                               dac_din_o,
  output logic                               dac_cs_o
);

  logic dac_start;
  logic dac_done;
  logic pixel;

  scan_ctrl_if scan_if ();

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // blocks
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  scan_fsm scan_fsm_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .dac_done_i  (dac_done),
    .dac_start_o (dac_start),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .ctrl        (scan_if.ctrl)
  );

  scan_counters scan_counters_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cnt   (scan_if.cnt)
  );

  dac_spi_writer dac_spi_writer_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (dac_start),
    .level_i (level_i),
    .done_o  (dac_done),
    .sclk_o  (dac_sclk_o),
    .din_o   (dac_din_o),
    .cs_o    (dac_cs_o)
  );

  frame_buffer frame_buffer_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (wr_en_i),
    .wr_data_i (wr_frame_i),
    .row_i     (scan_if.row_cnt),
    .col_i     (scan_if.col_cnt),
    .pixel_o   (pixel)
  );

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line drivers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // row lit for the whole dwell, column only for a set pixel.
  assign row_o = scan_if.dwell_en ?
                 (led_matrix_pkg::ROWS'(1) << scan_if.row_cnt) : '0;
  assign col_o = (scan_if.dwell_en && pixel) ?
                 (led_matrix_pkg::COLS'(1) << scan_if.col_cnt) : '0;

endmodule

// File: verilog/scan_counters.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Row and column counters driven by clear, hold
// and increment codes, plus the per-pixel dwell timer.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scan_counters (
  input  logic       clk_i,
  input  logic       rst_i,
  scan_ctrl_if.cnt   cnt
);

  logic [led_matrix_pkg::ROW_W-1:0]   row_q;
  logic [led_matrix_pkg::COL_W-1:0]   col_q;
  logic [led_matrix_pkg::DWELL_W-1:0] dwell_q;

  // counters wrap naturally at the matrix edge.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      row_q <= '0;
      col_q <= '0;
    end else begin
      case (cnt.row_op)
        led_matrix_pkg::OP_CLEAR: row_q <= '0;
        led_matrix_pkg::OP_INC:   row_q <= row_q + 1'b1;
        default:                  row_q <= row_q;
      endcase
      case (cnt.col_op)
        led_matrix_pkg::OP_CLEAR: col_q <= '0;
        led_matrix_pkg::OP_INC:   col_q <= col_q + 1'b1;
        default:                  col_q <= col_q;
      endcase
    end
  end

  // dwell timer runs only while the pixel is enabled.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      dwell_q <= '0;
    end else if (cnt.dwell_en) begin
      dwell_q <= dwell_q + 1'b1;
    end else begin
      dwell_q <= '0;
    end
  end

  assign cnt.row_cnt    = row_q;
  assign cnt.col_cnt    = col_q;
  // flags the last enabled cycle of the pixel.
  assign cnt.dwell_done =
    (dwell_q == led_matrix_pkg::DWELL_W'(led_matrix_pkg::DWELL_CYCLES - 1));

endmodule

// File: verilog/scan_ctrl_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link between the scan controller and the counter
// block: counter operations out, counts and dwell
// status back.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface scan_ctrl_if;

  led_matrix_pkg::cnt_op_t             row_op;
  led_matrix_pkg::cnt_op_t             col_op;
  logic                                dwell_en;
  logic [led_matrix_pkg::ROW_W-1:0]    row_cnt;
  logic [led_matrix_pkg::COL_W-1:0]    col_cnt;
  logic                                dwell_done;

  // controller side.
  modport ctrl (
    output row_op, col_op, dwell_en,
    input  row_cnt, col_cnt, dwell_done
  );

  // counter side.
  modport cnt (
    input  row_op, col_op, dwell_en,
    output row_cnt, col_cnt, dwell_done
  );

endinterface

// File: verilog/scan_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan controller. Loads the DAC on start, then
// walks the pixels in raster order using the
// counter block.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scan_fsm (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         start_i,
  input  logic         dac_done_i,
  output logic         dac_start_o,
  output logic         busy_o,
  output logic         done_o,
  scan_ctrl_if.ctrl    ctrl
);

  led_matrix_pkg::scan_state_t state_q, state_d;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= led_matrix_pkg::S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    dac_start_o   = 1'b0;
    ctrl.dwell_en = 1'b0;
    ctrl.row_op   = led_matrix_pkg::OP_HOLD;
    ctrl.col_op   = led_matrix_pkg::OP_HOLD;
    busy_o        = 1'b1;
    done_o        = 1'b0;
    case (state_q)
      led_matrix_pkg::S_IDLE: begin
        ctrl.row_op = led_matrix_pkg::OP_CLEAR;
        ctrl.col_op = led_matrix_pkg::OP_CLEAR;
        busy_o      = 1'b0;
        done_o      = 1'b1;
        if (start_i) begin
          state_d = led_matrix_pkg::S_DAC_START;
        end
      end
      led_matrix_pkg::S_DAC_START: begin
        dac_start_o = 1'b1;
        state_d     = led_matrix_pkg::S_DAC_WAIT;
      end
      led_matrix_pkg::S_DAC_WAIT: begin
        if (dac_done_i) begin
          state_d = led_matrix_pkg::S_DWELL;
        end
      end
      led_matrix_pkg::S_DWELL: begin
        ctrl.dwell_en = 1'b1;
        if (ctrl.dwell_done) begin
          state_d = led_matrix_pkg::S_COL_STEP;
        end
      end
      led_matrix_pkg::S_COL_STEP: begin
        ctrl.col_op = led_matrix_pkg::OP_INC;
        state_d     = led_matrix_pkg::S_COL_TEST;
      end
      led_matrix_pkg::S_COL_TEST: begin
        // column wrapped past the last index.
        if (ctrl.col_cnt == '0) begin
          state_d = led_matrix_pkg::S_ROW_STEP;
        end else begin
          state_d = led_matrix_pkg::S_DWELL;
        end
      end
      led_matrix_pkg::S_ROW_STEP: begin
        ctrl.row_op = led_matrix_pkg::OP_INC;
        ctrl.col_op = led_matrix_pkg::OP_CLEAR;
        state_d     = led_matrix_pkg::S_ROW_TEST;
      end
      led_matrix_pkg::S_ROW_TEST: begin
        if (ctrl.row_cnt == '0) begin
          state_d = led_matrix_pkg::S_IDLE;
        end else begin
          state_d = led_matrix_pkg::S_DWELL;
        end
      end
      default: begin
        state_d = led_matrix_pkg::S_IDLE;
      end
    endcase
  end

endmodule
